// File: compile.f
hw/vec_pkg.sv
hw/vec_lane_if.sv
hw/vec_dispatcher.sv
hw/vec_sequencer.sv
hw/vec_lane.sv
hw/vec_result_unit.sv
hw/vec_top.sv
tb/vec_asserts.sv
tb/vec_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module vec_tb -Mdir obj_dir

out=$(./obj_dir/Vvec_tb 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// File: tb/vec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vec_tb import vec_pkg::*; ();

  localparam int ResetExts     = 8;
  localparam int AluOps        = 40;
  localparam int Reductions    = 20;
  localparam int MixedOps      = 24;
  localparam int Intrusions    = 12;
  localparam int BadVlStrobes  = 8;
  localparam int Readback      = NrVRegs * VlMax;
  localparam int InsnCycles    = 6;
  localparam int TotalInsns    = ResetExts + AluOps + Reductions + MixedOps + Intrusions
                                 + BadVlStrobes + 2 * Readback;
  localparam int TimeoutCycles = 2 * TotalInsns * InsnCycles + 200;

  logic      clk_i;
  logic      rst_n_i;
  logic      insn_valid_i;
  vec_op_e   insn_op_i;
  vreg_idx_t insn_vd_i;
  vreg_idx_t insn_vs1_i;
  vreg_idx_t insn_vs2_i;
  elem_t     insn_scalar_i;
  vl_t       insn_vl_i;
  logic      busy_o;
  logic      drop_o;
  logic      done_o;
  logic      result_valid_o;
  elem_t     result_o;

  // Reference register file indexed by register then element
  elem_t  model [NrVRegs][VlMax];
  integer seed;
  int     errors;
  int     test_base;
  int     tests_run;
  int     tests_failed;
  int     assert_seen;
  int     cycle_cnt = 0;
  string  cur_test;

  vec_top vec_top_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .insn_valid_i   (insn_valid_i),
    .insn_op_i      (insn_op_i),
    .insn_vd_i      (insn_vd_i),
    .insn_vs1_i     (insn_vs1_i),
    .insn_vs2_i     (insn_vs2_i),
    .insn_scalar_i  (insn_scalar_i),
    .insn_vl_i      (insn_vl_i),
    .busy_o         (busy_o),
    .drop_o         (drop_o),
    .done_o         (done_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] rnd();
    rnd = $random(seed);
  endfunction

  task automatic check(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_base = errors;
    tests_run++;
  endtask

  task automatic end_test();
    int fresh;
    // Protocol property failures during this test count as errors too
    fresh       = vec_top_inst.vec_asserts_inst.fail_cnt - assert_seen;
    assert_seen = assert_seen + fresh;
    errors      = errors + fresh;
    if (errors == test_base) begin
      $display("PASS %s", cur_test);
    end else begin
      $display("FAIL %s: %0d errors", cur_test, errors - test_base);
      tests_failed++;
    end
  endtask

  task automatic drive_random_fields(input vl_t vl);
    insn_valid_i  = 1'b1;
    insn_op_i     = vec_op_e'(3'(rnd()));
    insn_vd_i     = vreg_idx_t'(rnd());
    insn_vs1_i    = vreg_idx_t'(rnd());
    insn_vs2_i    = vreg_idx_t'(rnd());
    insn_scalar_i = elem_t'(rnd());
    insn_vl_i     = vl;
  endtask

  // Scalar result uses the old state before the register write
  task automatic model_step(input vec_op_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                            input vreg_idx_t vs2, input elem_t scalar, input vl_t vl,
                            output logic has_res, output elem_t res);
    elem_t a;
    elem_t b;
    has_res = 1'b0;
    res     = '0;
    if (op == VREDSUM) begin
      has_res = 1'b1;
      res     = model[vs1][0];
      for (int i = 0; i < int'(vl); i++) begin
        res = res + model[vs2][i];
      end
    end else if (op == VEXT) begin
      // Index is the scalar mod 16 and vl plays no part
      has_res = 1'b1;
      res     = model[vs2][scalar[3:0]];
    end else begin
      for (int i = 0; i < int'(vl); i++) begin
        a = model[vs1][i];
        b = model[vs2][i];
        case (op)
          VADD:    model[vd][i] = a + b;
          VSUB:    model[vd][i] = a - b;
          VAND:    model[vd][i] = a & b;
          VOR:     model[vd][i] = a | b;
          VXOR:    model[vd][i] = a ^ b;
          default: model[vd][i] = scalar;
        endcase
      end
    end
  endtask

  // Runs one instruction with an optional second strobe while busy
  task automatic exec_insn(input vec_op_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                           input vreg_idx_t vs2, input elem_t scalar, input vl_t vl,
                           input int intrude_at);
    int    lat;
    logic  dropped;
    logic  exp_valid;
    elem_t exp_res;
    insn_valid_i  = 1'b1;
    insn_op_i     = op;
    insn_vd_i     = vd;
    insn_vs1_i    = vs1;
    insn_vs2_i    = vs2;
    insn_scalar_i = scalar;
    insn_vl_i     = vl;
    @(negedge clk_i);
    insn_valid_i = 1'b0;
    lat          = 0;
    dropped      = 1'b0;
    model_step(op, vd, vs1, vs2, scalar, vl, exp_valid, exp_res);
    while (!done_o && lat < 3 * InsnCycles) begin
      dropped = dropped | drop_o;
      assert (busy_o) else begin
        $display("ERROR %s: busy_o is low while an instruction is in flight", cur_test);
        errors++;
      end
      if (lat == intrude_at) begin
        drive_random_fields(vl_t'(rnd()));
      end else begin
        insn_valid_i = 1'b0;
      end
      @(negedge clk_i);
      lat++;
    end
    check("latency", 5, lat);
    check("result_valid_o", int'(exp_valid), int'(result_valid_o));
    if (exp_valid) begin
      check("result_o", int'(exp_res), int'(result_o));
    end
    assert (dropped == (intrude_at >= 0)) else begin
      $display("ERROR %s: drop_o did not match the strobes issued while busy", cur_test);
      errors++;
    end
  endtask

  task automatic strobe_bad_vl();
    drive_random_fields(vl_t'(17 + rnd() % 15));
    @(negedge clk_i);
    insn_valid_i = 1'b0;
    assert (drop_o && !busy_o) else begin
      $display("ERROR %s: a strobe with vl above 16 was not dropped", cur_test);
      errors++;
    end
  endtask

  task automatic readback_all();
    logic [31:0] up;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < VlMax; i++) begin
        up = rnd();
        exec_insn(VEXT, vreg_idx_t'(rnd()), vreg_idx_t'(rnd()), vreg_idx_t'(r),
                  {up[11:0], 4'(i)}, vl_t'(rnd() % 17), -1);
      end
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    seed          = 56585;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    assert_seen   = 0;
    rst_n_i       = 1'b0;
    insn_valid_i  = 1'b0;
    insn_op_i     = VADD;
    insn_vd_i     = '0;
    insn_vs1_i    = '0;
    insn_vs2_i    = '0;
    insn_scalar_i = '0;
    insn_vl_i     = '0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < VlMax; i++) begin
        model[r][i] = '0;
      end
    end
    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b1;

    start_test("reset_state");
    check("control outputs", 0, int'({busy_o, drop_o, done_o, result_valid_o}));
    for (int n = 0; n < ResetExts; n++) begin
      exec_insn(VEXT, '0, '0, vreg_idx_t'(rnd()), elem_t'(rnd()), '0, -1);
    end
    end_test();

    start_test("elementwise_ops");
    for (int n = 0; n < AluOps; n++) begin
      exec_insn(vec_op_e'(3'(rnd() % 6)), vreg_idx_t'(rnd()), vreg_idx_t'(rnd()),
                vreg_idx_t'(rnd()), elem_t'(rnd()), vl_t'(rnd() % 17), -1);
    end
    readback_all();
    end_test();

    start_test("reduction");
    for (int n = 0; n < Reductions; n++) begin
      exec_insn(VREDSUM, vreg_idx_t'(rnd()), vreg_idx_t'(rnd()), vreg_idx_t'(rnd()),
                elem_t'(rnd()), (n == 0) ? vl_t'(0) : (n == 1) ? vl_t'(16) : vl_t'(rnd() % 17),
                -1);
    end
    end_test();

    // Latency and result_valid_o are checked on every op kind
    start_test("fixed_latency");
    for (int n = 0; n < MixedOps; n++) begin
      exec_insn(vec_op_e'(3'(rnd())), vreg_idx_t'(rnd()), vreg_idx_t'(rnd()),
                vreg_idx_t'(rnd()), elem_t'(rnd()), vl_t'(rnd() % 17), -1);
    end
    end_test();

    start_test("drops");
    for (int n = 0; n < Intrusions; n++) begin
      exec_insn(vec_op_e'(3'(rnd())), vreg_idx_t'(rnd()), vreg_idx_t'(rnd()),
                vreg_idx_t'(rnd()), elem_t'(rnd()), vl_t'(rnd() % 17), int'(rnd() % 4));
    end
    for (int n = 0; n < BadVlStrobes; n++) begin
      strobe_bad_vl();
    end
    readback_all();
    end_test();

    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/vec_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module vec_asserts (
  input wire clk_i,
  input wire rst_n_i,
  input wire insn_valid_i,
  input wire busy_i,
  input wire drop_i,
  input wire done_i,
  input wire result_valid_i
);

  // Count of failed properties
  int fail_cnt = 0;

  // Done is a single cycle pulse
  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |=> !done_i)
    else begin
      $error("done_o stayed high for more than one cycle");
      fail_cnt++;
    end

  busy_not_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(busy_i && done_i))
    else begin
      $error("busy_o and done_o are high in the same cycle");
      fail_cnt++;
    end

  valid_with_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_i |-> done_i)
    else begin
      $error("result_valid_o is high without done_o");
      fail_cnt++;
    end

  // A drop answers a strobe on the previous edge
  drop_after_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    drop_i |-> $past(insn_valid_i))
    else begin
      $error("drop_o pulsed without a preceding strobe");
      fail_cnt++;
    end

endmodule

bind vec_top vec_asserts vec_asserts_inst (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .insn_valid_i   (insn_valid_i),
  .busy_i         (busy_o),
  .drop_i         (drop_o),
  .done_i         (done_o),
  .result_valid_i (result_valid_o)
);

`default_nettype wire

// File: hw/vec_top.sv
`timescale 1ns/1ps
`default_nettype none

module vec_top import vec_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_n_i,
  input  wire        insn_valid_i,
  input  vec_op_e    insn_op_i,
  input  vreg_idx_t  insn_vd_i,
  input  vreg_idx_t  insn_vs1_i,
  input  vreg_idx_t  insn_vs2_i,
  input  elem_t      insn_scalar_i,
  input  vl_t        insn_vl_i,
  output logic       busy_o,
  output logic       drop_o,
  output logic       done_o,
  output logic       result_valid_o,
  output elem_t      result_o
);

  // Dispatcher to sequencer
  logic      start;
  logic      finish;
  vec_op_e   req_op;
  vreg_idx_t req_vd;
  vreg_idx_t req_vs1;
  vreg_idx_t req_vs2;
  elem_t     req_scalar;
  vl_t       req_vl;

  lane_result_t lane_res [NrLanes];

  vec_lane_if lane_if ();

  vec_dispatcher i_dispatcher (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .insn_valid_i  (insn_valid_i),
    .insn_op_i     (insn_op_i),
    .insn_vd_i     (insn_vd_i),
    .insn_vs1_i    (insn_vs1_i),
    .insn_vs2_i    (insn_vs2_i),
    .insn_scalar_i (insn_scalar_i),
    .insn_vl_i     (insn_vl_i),
    .finish_i      (finish),
    .start_o       (start),
    .op_o          (req_op),
    .vd_o          (req_vd),
    .vs1_o         (req_vs1),
    .vs2_o         (req_vs2),
    .scalar_o      (req_scalar),
    .vl_o          (req_vl),
    .busy_o        (busy_o),
    .drop_o        (drop_o)
  );

  vec_sequencer i_sequencer (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (start),
    .op_i     (req_op),
    .vd_i     (req_vd),
    .vs1_i    (req_vs1),
    .vs2_i    (req_vs2),
    .scalar_i (req_scalar),
    .vl_i     (req_vl),
    .finish_o (finish),
    .lane_if  (lane_if.seq)
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .LaneId (l)
    ) i_lane (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .lane_if    (lane_if.lane),
      .lane_res_o (lane_res[l])
    );
  end

  vec_result_unit i_result_unit (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .lane_if        (lane_if.monitor),
    .lane_res_i     (lane_res),
    .done_o         (done_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

`default_nettype wire

// File: hw/vec_result_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vec_result_unit import vec_pkg::*; (
  input  wire           clk_i,
  input  wire           rst_n_i,
  vec_lane_if.monitor   lane_if,
  input  lane_result_t  lane_res_i [NrLanes],
  output logic          done_o,
  output logic          result_valid_o,
  output elem_t         result_o
);

  logic      pend_q;
  vec_op_e   op_q;
  lane_idx_t sel_q;
  elem_t     red_sum;
  logic      done_q;
  logic      res_valid_q;
  elem_t     result_q;

  // Wraps at the element width like the lanes do
  always_comb begin
    red_sum = '0;
    for (int l = 0; l < NrLanes; l++) begin
      red_sum = red_sum + lane_res_i[l].psum;
    end
  end

  ////////////////////////////////////////
  // Two stage completion
  ////////////////////////////////////////

  // Stage 1 notes the last step, stage 2 reads the settled lane results
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q      <= 1'b0;
      done_q      <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      pend_q      <= lane_if.valid & lane_if.last;
      done_q      <= pend_q;
      res_valid_q <= pend_q & (op_q inside {VREDSUM, VEXT});
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_if.valid && lane_if.last) begin
      op_q  <= lane_if.op;
      sel_q <= lane_if.scalar[$bits(lane_idx_t)-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (pend_q) begin
      result_q <= (op_q == VREDSUM) ? red_sum : lane_res_i[sel_q].elem;
    end
  end

  assign done_o         = done_q;
  assign result_valid_o = res_valid_q;
  assign result_o       = result_q;

endmodule

`default_nettype wire

// File: hw/vec_lane.sv
`timescale 1ns/1ps
`default_nettype none

module vec_lane import vec_pkg::*; #(
  parameter int unsigned LaneId = 0
) (
  input  wire           clk_i,
  input  wire           rst_n_i,
  vec_lane_if.lane      lane_if,
  output lane_result_t  lane_res_o
);

  // Register file slice, element slot*NrLanes + LaneId of every register
  elem_t rf_q [NrVRegs][ElemsPerLane];

  vl_t   elem_idx;
  logic  in_vl;
  elem_t vs1_elem;
  elem_t vs2_elem;
  elem_t alu_res;
  logic  wr_en;

  elem_t psum_q;
  elem_t psum_d;
  elem_t red_base;
  elem_t red_vs1;
  elem_t red_vs2;
  elem_t capt_q;
  slot_t ext_slot;

  assign elem_idx = vl_t'({lane_if.slot, lane_idx_t'(LaneId)});
  assign in_vl    = (elem_idx < lane_if.vl);

  assign vs1_elem = rf_q[lane_if.vs1][lane_if.slot];
  assign vs2_elem = rf_q[lane_if.vs2][lane_if.slot];

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    unique case (lane_if.op)
      VADD:    alu_res = vs1_elem + vs2_elem;
      VSUB:    alu_res = vs1_elem - vs2_elem;
      VAND:    alu_res = vs1_elem & vs2_elem;
      VOR:     alu_res = vs1_elem | vs2_elem;
      VXOR:    alu_res = vs1_elem ^ vs2_elem;
      VMVX:    alu_res = lane_if.scalar;
      default: alu_res = '0;
    endcase
  end

  // Tail elements are left alone
  assign wr_en = lane_if.valid & in_vl & !(lane_if.op inside {VREDSUM, VEXT});

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < NrVRegs; r++) begin
        for (int s = 0; s < ElemsPerLane; s++) begin
          rf_q[r][s] <= '0;
        end
      end
    end else if (wr_en) begin
      rf_q[lane_if.vd][lane_if.slot] <= alu_res;
    end
  end

  ////////////////////////////////////////
  // Reduction
  ////////////////////////////////////////

  // Slot 0 restarts the partial sum
  always_comb begin
    red_base = (lane_if.slot == '0) ? elem_t'(0) : psum_q;
    red_vs2  = in_vl ? vs2_elem : elem_t'(0);
    // vs1[0] lives in lane 0 slot 0 and is added regardless of vl
    red_vs1  = (LaneId == 0 && lane_if.slot == '0) ? vs1_elem : elem_t'(0);
  end

  assign psum_d = red_base + red_vs2 + red_vs1;

  always_ff @(posedge clk_i) begin
    if (lane_if.valid && lane_if.op == VREDSUM) begin
      psum_q <= psum_d;
    end
  end

  ////////////////////////////////////////
  // Element extraction
  ////////////////////////////////////////

  // Upper index bits pick the slot, the lower ones the lane
  assign ext_slot = lane_if.scalar[$bits(lane_idx_t) +: $bits(slot_t)];

  always_ff @(posedge clk_i) begin
    if (lane_if.valid && lane_if.op == VEXT && lane_if.slot == ext_slot) begin
      capt_q <= vs2_elem;
    end
  end

  assign lane_res_o.psum = psum_q;
  assign lane_res_o.elem = capt_q;

endmodule

`default_nettype wire

// File: hw/vec_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer import vec_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_n_i,
  input  wire        start_i,
  input  vec_op_e    op_i,
  input  vreg_idx_t  vd_i,
  input  vreg_idx_t  vs1_i,
  input  vreg_idx_t  vs2_i,
  input  elem_t      scalar_i,
  input  vl_t        vl_i,
  output logic       finish_o,
  vec_lane_if.seq    lane_if
);

  seq_state_e state_q;
  slot_t      slot_q;
  logic       step;
  logic       last;
  logic       finish_q;

  // Slot 0 goes out in the start cycle itself
  assign step = start_i | (state_q == RUN);
  assign last = step & (slot_q == slot_t'(ElemsPerLane - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      slot_q   <= '0;
      finish_q <= 1'b0;
    end else begin
      finish_q <= last;
      if (step) begin
        // Counter wraps back to 0 after the last slot
        slot_q <= slot_q + slot_t'(1);
      end
      unique case (state_q)
        IDLE: if (start_i) state_q <= RUN;
        RUN:  if (last) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Step broadcast
  ////////////////////////////////////////

  assign lane_if.valid  = step;
  assign lane_if.op     = op_i;
  assign lane_if.vd     = vd_i;
  assign lane_if.vs1    = vs1_i;
  assign lane_if.vs2    = vs2_i;
  assign lane_if.scalar = scalar_i;
  assign lane_if.vl     = vl_i;
  assign lane_if.slot   = slot_q;
  assign lane_if.last   = last;

  assign finish_o = finish_q;

endmodule

`default_nettype wire

// File: hw/vec_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher import vec_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_n_i,
  input  wire        insn_valid_i,
  input  vec_op_e    insn_op_i,
  input  vreg_idx_t  insn_vd_i,
  input  vreg_idx_t  insn_vs1_i,
  input  vreg_idx_t  insn_vs2_i,
  input  elem_t      insn_scalar_i,
  input  vl_t        insn_vl_i,
  input  wire        finish_i,
  output logic       start_o,
  output vec_op_e    op_o,
  output vreg_idx_t  vd_o,
  output vreg_idx_t  vs1_o,
  output vreg_idx_t  vs2_o,
  output elem_t      scalar_o,
  output vl_t        vl_o,
  output logic       busy_o,
  output logic       drop_o
);

  logic accept;
  logic reject;
  logic vl_ok;
  logic start_q;
  logic busy_q;
  logic drop_q;

  // The finishing cycle already counts as free
  assign vl_ok  = (insn_vl_i <= vl_t'(VlMax));
  assign accept = insn_valid_i & vl_ok & (~busy_q | finish_i);
  assign reject = insn_valid_i & ~accept;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      drop_q  <= 1'b0;
    end else begin
      start_q <= accept;
      drop_q  <= reject;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (finish_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Request stays put until the next accepted strobe
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_o     <= insn_op_i;
      vd_o     <= insn_vd_i;
      vs1_o    <= insn_vs1_i;
      vs2_o    <= insn_vs2_i;
      scalar_o <= insn_scalar_i;
      vl_o     <= insn_vl_i;
    end
  end

  assign start_o = start_q;
  assign busy_o  = busy_q;
  assign drop_o  = drop_q;

endmodule

`default_nettype wire

// File: hw/vec_lane_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vec_lane_if import vec_pkg::*; ();

  // One step per cycle with valid high
  logic      valid;
  vec_op_e   op;
  vreg_idx_t vd;
  vreg_idx_t vs1;
  vreg_idx_t vs2;
  elem_t     scalar;
  vl_t       vl;
  slot_t     slot;
  logic      last;

  modport seq (
    output valid, op, vd, vs1, vs2, scalar, vl, slot, last
  );

  // Lanes do not care which step is the final one
  modport lane (
    input valid, op, vd, vs1, vs2, scalar, vl, slot
  );

  modport monitor (
    input valid, op, scalar, last
  );

endinterface

`default_nettype wire

// File: hw/vec_pkg.sv
`default_nettype none

package vec_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 4;
  localparam int unsigned VlMax        = NrLanes * ElemsPerLane;
  localparam int unsigned ElemWidth    = 16;
  localparam int unsigned NrVRegs      = 8;

  typedef logic [ElemWidth-1:0]             elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]       vreg_idx_t;
  // One extra bit so that vl can reach VlMax
  typedef logic [$clog2(VlMax+1)-1:0]       vl_t;
  typedef logic [$clog2(ElemsPerLane)-1:0]  slot_t;
  typedef logic [$clog2(NrLanes)-1:0]       lane_idx_t;

  ////////////////////////////////////////
  // Opcodes and states
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    VADD    = 3'd0,
    VSUB    = 3'd1,
    VAND    = 3'd2,
    VOR     = 3'd3,
    VXOR    = 3'd4,
    VMVX    = 3'd5,  // scalar broadcast into vd
    VREDSUM = 3'd6,
    VEXT    = 3'd7
  } vec_op_e;

  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } seq_state_e;

  // What one lane hands to the result unit
  typedef struct packed {
    elem_t psum;
    elem_t elem;
  } lane_result_t;

endpackage

`default_nettype wire
